// ==== iopred.f ====
+incdir+hdl
hdl/iopred_pkg.sv
hdl/mem_pred_if.sv
hdl/memory_io_predication.sv
hdl/io_ready_combiner.sv
hdl/datapath_io_predication.sv
tb/tb_datapath_io_predication.sv

// ==== Makefile ====
# Verilator build and run for the I/O predication stage

SIM := obj_dir/Vtb_datapath_io_predication

.PHONY: all run clean

all: $(SIM)

$(SIM): iopred.f hdl/iopred_consts.svh hdl/iopred_pkg.sv hdl/mem_pred_if.sv \
		hdl/memory_io_predication.sv hdl/io_ready_combiner.sv \
		hdl/datapath_io_predication.sv tb/tb_datapath_io_predication.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_datapath_io_predication -f iopred.f

# The simulation reads its cases relative to the project root
run: $(SIM) tb/io_pred_cases.txt
	./$(SIM) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== tb/io_pred_cases.txt ====
# name  ra_a ra_b wa_a wa_b  ref_a ref_b wef_a wef_b cancel
#       exp: rden_a rden_b read_io_a read_io_b write_io_a write_io_b io_ready  (all hex)
plain_low         000 400 000 400  f f f f 0  0 0 0 0 0 0 1
plain_flags_low   123 523 3fb 7fb  0 0 0 0 0  0 0 0 0 0 0 1
plain_below_port  3fb 7fb 200 600  0 0 0 0 0  0 0 0 0 0 0 1
rd_a_port0        3fc 400 000 400  f f f f 0  1 0 1 0 0 0 1
rd_a_port1        3fd 400 000 400  f f f f 0  2 0 1 0 0 0 1
rd_a_port2        3fe 400 000 400  f f f f 0  4 0 1 0 0 0 1
rd_a_port3        3ff 400 000 400  f f f f 0  8 0 1 0 0 0 1
rd_b_port0        000 7fc 000 400  f f f f 0  0 1 0 1 0 0 1
rd_b_port1        000 7fd 000 400  f f f f 0  0 2 0 1 0 0 1
rd_b_port2        000 7fe 000 400  f f f f 0  0 4 0 1 0 0 1
rd_b_port3        000 7ff 000 400  f f f f 0  0 8 0 1 0 0 1
rd_both           3fd 7fe 000 400  f f f f 0  2 4 1 1 0 0 1
rd_a_flag_only    3fc 400 000 400  1 0 0 0 0  1 0 1 0 0 0 1
rd_b_flag_only    000 7ff 000 400  0 8 0 0 0  0 8 0 1 0 0 1
rd_a_empty        3fe 7fc 000 400  b f f f 0  0 0 1 1 0 0 0
rd_b_empty        3fc 7fd 000 400  f d f f 0  0 0 1 1 0 0 0
rd_a_other_empty  3fe 400 000 400  7 0 f f 0  4 0 1 0 0 0 1
wr_a_full         3fc 400 3ff 400  f f 7 f 0  0 0 1 0 1 0 0
wr_b_full         000 7fd 000 7fc  f f f e 0  0 0 0 1 0 1 0
wr_b_ready        000 7ff 000 7fd  f f f e 0  0 8 0 1 0 1 1
wr_a_other_full   3fd 400 3fe 400  f f 4 f 0  2 0 1 0 1 0 1
cancel_read       3fc 7ff 000 400  f f f f 1  0 0 1 1 0 0 1
cancel_write      3fd 400 3fc 7fe  f f f f 1  0 0 1 0 1 1 1
cancel_empty      3fd 400 000 400  d f f f 1  0 0 1 0 0 0 0
a_addr_in_b       7fc 400 7fd 400  0 f 0 f 0  0 0 0 0 0 0 1
b_addr_in_a       400 3fc 400 3ff  f 0 f 0 0  0 0 0 0 0 0 1
wr_beyond_b       000 400 bfc bfd  0 0 0 0 0  0 0 0 0 0 0 1
wr_top            000 400 fff fff  0 0 0 0 0  0 0 0 0 0 0 1
wr_past_b         000 400 7fc 800  0 0 0 0 0  0 0 0 0 0 0 1
b2b_ready         3fc 7fc 3ff 7ff  f f f f 0  1 1 1 1 1 1 1
b2b_stall         3fc 7fc 3ff 7ff  f f f 7 0  0 0 1 1 1 1 0
b2b_resume        3fc 7fc 3ff 7ff  f f f f 0  1 1 1 1 1 1 1
b2b_switch        3ff 7fd 000 400  8 2 0 0 0  8 2 1 1 0 0 1
b2b_plain         000 400 000 400  0 0 0 0 0  0 0 0 0 0 0 1

// ==== tb/tb_datapath_io_predication.sv ====
// Datapath I/O predication testbench

`timescale 1ns/1ps

module tb_datapath_io_predication import iopred_pkg::*; ();

    localparam int    max_cases  = 64;
    localparam string cases_file = "tb/io_pred_cases.txt";

    logic        clock;
    logic        reset;
    logic        cancel;
    read_addr_t  read_addr_a;
    read_addr_t  read_addr_b;
    write_addr_t write_addr_a;
    write_addr_t write_addr_b;
    port_mask_t  read_ef_a;
    port_mask_t  read_ef_b;
    port_mask_t  write_ef_a;
    port_mask_t  write_ef_b;

    port_mask_t  io_rden_a;
    port_mask_t  io_rden_b;
    logic        read_is_io_a;
    logic        read_is_io_b;
    logic        write_is_io_a;
    logic        write_is_io_b;
    logic        io_ready;

    // Case table, one entry per line of the cases file
    string       case_name   [max_cases];
    read_addr_t  case_ra_a   [max_cases];
    read_addr_t  case_ra_b   [max_cases];
    write_addr_t case_wa_a   [max_cases];
    write_addr_t case_wa_b   [max_cases];
    port_mask_t  case_ref_a  [max_cases];
    port_mask_t  case_ref_b  [max_cases];
    port_mask_t  case_wef_a  [max_cases];
    port_mask_t  case_wef_b  [max_cases];
    logic        case_cancel [max_cases];
    port_mask_t  exp_rden_a  [max_cases];
    port_mask_t  exp_rden_b  [max_cases];
    logic        exp_ri_a    [max_cases];
    logic        exp_ri_b    [max_cases];
    logic        exp_wi_a    [max_cases];
    logic        exp_wi_b    [max_cases];
    logic        exp_ready   [max_cases];
    int          case_errors [max_cases];

    int          n_cases;
    int          pass_count;
    int          fail_count;
    bit          load_ok;
    logic        loaded;

    datapath_io_predication UUT (
        .clock         (clock),
        .reset         (reset),
        .cancel        (cancel),
        .read_addr_a   (read_addr_a),
        .read_addr_b   (read_addr_b),
        .write_addr_a  (write_addr_a),
        .write_addr_b  (write_addr_b),
        .read_ef_a     (read_ef_a),
        .read_ef_b     (read_ef_b),
        .write_ef_a    (write_ef_a),
        .write_ef_b    (write_ef_b),
        .io_rden_a     (io_rden_a),
        .io_rden_b     (io_rden_b),
        .read_is_io_a  (read_is_io_a),
        .read_is_io_b  (read_is_io_b),
        .write_is_io_a (write_is_io_a),
        .write_is_io_b (write_is_io_b),
        .io_ready      (io_ready)
    );

    always #5 clock = ~clock;

    // ------------------------------------------------------------
    // Case loading
    // ------------------------------------------------------------

    task automatic load_cases(output bit ok);
        int                 fd;
        int                 code;
        string              tok;
        logic [8*160-1:0]   rest_buf;
        bit                 done;
        bit                 bad;
        done    = 1'b0;
        bad     = 1'b0;
        ok      = 1'b0;
        n_cases = 0;
        fd = $fopen(cases_file, "r");
        if (fd != 0) begin
            while (!done) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tok[0] == "#") begin
                    code = $fgets(rest_buf, fd);
                end else if (n_cases >= max_cases) begin
                    $display("More cases in %s than the table can hold", cases_file);
                    bad  = 1'b1;
                    done = 1'b1;
                end else begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        case_ra_a[n_cases], case_ra_b[n_cases],
                        case_wa_a[n_cases], case_wa_b[n_cases],
                        case_ref_a[n_cases], case_ref_b[n_cases],
                        case_wef_a[n_cases], case_wef_b[n_cases],
                        case_cancel[n_cases],
                        exp_rden_a[n_cases], exp_rden_b[n_cases],
                        exp_ri_a[n_cases], exp_ri_b[n_cases],
                        exp_wi_a[n_cases], exp_wi_b[n_cases],
                        exp_ready[n_cases]);
                    if (code != 16) begin
                        $display("Case %s in %s has missing or unreadable fields",
                                 tok, cases_file);
                        bad  = 1'b1;
                        done = 1'b1;
                    end else begin
                        case_name[n_cases]   = tok;
                        case_errors[n_cases] = 0;
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
            ok = !bad && (n_cases > 0);
        end
    endtask

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------

    // Cycle N of case k, or a plain memory access when past the table
    task automatic drive_addresses(input int k);
        if (k < n_cases) begin
            read_addr_a  = case_ra_a[k];
            read_addr_b  = case_ra_b[k];
            write_addr_a = case_wa_a[k];
            write_addr_b = case_wa_b[k];
        end else begin
            read_addr_a  = '0;
            read_addr_b  = read_addr_t'(1024);
            write_addr_a = '0;
            write_addr_b = write_addr_t'(1024);
        end
    endtask

    // Cycle N+1 of case k, where the port status is known
    task automatic drive_status(input int k);
        if (k >= 0 && k < n_cases) begin
            read_ef_a  = case_ref_a[k];
            read_ef_b  = case_ref_b[k];
            write_ef_a = case_wef_a[k];
            write_ef_b = case_wef_b[k];
            cancel     = case_cancel[k];
        end else begin
            read_ef_a  = '1;
            read_ef_b  = '1;
            write_ef_a = '1;
            write_ef_b = '1;
            cancel     = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // Checkers
    // ------------------------------------------------------------

    task automatic check_mask(input string test_name, input string signal_name,
                              input port_mask_t expected, input port_mask_t actual,
                              inout int errors);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %h, actual %h",
                     test_name, signal_name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_bit(input string test_name, input string signal_name,
                             input logic expected, input logic actual,
                             inout int errors);
        assert (actual === expected) else begin
            $display("FAILED %s: %s expected %b, actual %b",
                     test_name, signal_name, expected, actual);
            errors++;
        end
    endtask

    task automatic count_result(input string test_name, input int errors);
        if (errors == 0) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s with %0d wrong values", test_name, errors);
        end
    endtask

    task automatic check_decode(input int k);
        check_mask(case_name[k], "io_rden_a", exp_rden_a[k], io_rden_a, case_errors[k]);
        check_mask(case_name[k], "io_rden_b", exp_rden_b[k], io_rden_b, case_errors[k]);
        check_bit(case_name[k], "read_is_io_a", exp_ri_a[k], read_is_io_a, case_errors[k]);
        check_bit(case_name[k], "read_is_io_b", exp_ri_b[k], read_is_io_b, case_errors[k]);
        check_bit(case_name[k], "write_is_io_a", exp_wi_a[k], write_is_io_a, case_errors[k]);
        check_bit(case_name[k], "write_is_io_b", exp_wi_b[k], write_is_io_b, case_errors[k]);
    endtask

    // io_ready is the last result of a case, so the case ends here
    task automatic check_ready(input int k);
        check_bit(case_name[k], "io_ready", exp_ready[k], io_ready, case_errors[k]);
        count_result(case_name[k], case_errors[k]);
    endtask

    task automatic check_reset_state();
        int errors;
        errors = 0;
        check_mask("reset_state", "io_rden_a", '0, io_rden_a, errors);
        check_mask("reset_state", "io_rden_b", '0, io_rden_b, errors);
        check_bit("reset_state", "read_is_io_a", 1'b0, read_is_io_a, errors);
        check_bit("reset_state", "read_is_io_b", 1'b0, read_is_io_b, errors);
        check_bit("reset_state", "write_is_io_a", 1'b0, write_is_io_a, errors);
        check_bit("reset_state", "write_is_io_b", 1'b0, write_is_io_b, errors);
        check_bit("reset_state", "io_ready", 1'b0, io_ready, errors);
        count_result("reset_state", errors);
    endtask

    // ------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------

    task automatic apply_reset();
        reset = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        @(negedge clock);
        check_reset_state();
    endtask

    // Case c enters while case c-1 gets its flags and case c-2 shows io_ready
    task automatic run_cases();
        for (int c = 0; c < n_cases + 2; c++) begin
            @(posedge clock);
            #1;
            drive_addresses(c);
            drive_status(c - 1);
            @(negedge clock);
            if (c >= 1 && c - 1 < n_cases) begin
                check_decode(c - 1);
            end
            if (c >= 2) begin
                check_ready(c - 2);
            end
        end
    endtask

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        loaded     = 1'b0;
        pass_count = 0;
        fail_count = 0;
        drive_addresses(max_cases);
        drive_status(-1);
        load_cases(load_ok);
        if (!load_ok) begin
            $display("Could not read the cases from %s", cases_file);
            $display("Test failed");
            $finish;
        end else begin
            loaded = 1'b1;
            apply_reset();
            run_cases();
            $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

    // Watchdog, sized from the number of cases once they are loaded
    initial begin
        wait (loaded === 1'b1);
        #((n_cases + 20) * 10);
        $display("Timeout: the cases did not finish within %0d cycles", n_cases + 20);
        $display("Test failed");
        $finish;
    end

endmodule

// ==== hdl/datapath_io_predication.sv ====
// Datapath I/O predication

`timescale 1ns/1ps

`include "iopred_consts.svh"

module datapath_io_predication import iopred_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        cancel,

    // Addresses of one instruction, cycle N
    input  read_addr_t  read_addr_a,
    input  read_addr_t  read_addr_b,
    input  write_addr_t write_addr_a,
    input  write_addr_t write_addr_b,

    // Port status for that instruction, cycle N+1
    input  port_mask_t  read_ef_a,
    input  port_mask_t  read_ef_b,
    input  port_mask_t  write_ef_a,
    input  port_mask_t  write_ef_b,

    output port_mask_t  io_rden_a,
    output port_mask_t  io_rden_b,
    output logic        read_is_io_a,
    output logic        read_is_io_b,
    output logic        write_is_io_a,
    output logic        write_is_io_b,

    // Valid in cycle N+2
    output logic        io_ready
);

    mem_pred_if mem_a_results ();
    mem_pred_if mem_b_results ();

    // ---------------------------------------------------------
    // Per-memory decode
    // ---------------------------------------------------------

    memory_io_predication #(
        .mem_base   (`MEM_A_BASE),
        .mem_bound  (`MEM_A_BOUND)
    ) mem_a_pred (
        .clock      (clock),
        .reset      (reset),
        .read_addr  (read_addr_a),
        .write_addr (write_addr_a),
        .read_ef    (read_ef_a),
        .write_ef   (write_ef_a),
        .results    (mem_a_results)
    );

    memory_io_predication #(
        .mem_base   (`MEM_B_BASE),
        .mem_bound  (`MEM_B_BOUND)
    ) mem_b_pred (
        .clock      (clock),
        .reset      (reset),
        .read_addr  (read_addr_b),
        .write_addr (write_addr_b),
        .read_ef    (read_ef_b),
        .write_ef   (write_ef_b),
        .results    (mem_b_results)
    );

    // ---------------------------------------------------------
    // Ready combination and read enable gating
    // ---------------------------------------------------------

    io_ready_combiner combiner (
        .clock      (clock),
        .reset      (reset),
        .cancel     (cancel),
        .mem_a      (mem_a_results),
        .mem_b      (mem_b_results),
        .io_rden_a  (io_rden_a),
        .io_rden_b  (io_rden_b),
        .io_ready   (io_ready)
    );

    assign read_is_io_a  = mem_a_results.read_is_io;
    assign read_is_io_b  = mem_b_results.read_is_io;
    assign write_is_io_a = mem_a_results.write_is_io;
    assign write_is_io_b = mem_b_results.write_is_io;

endmodule

// ==== hdl/io_ready_combiner.sv ====
// I/O ready combiner

`timescale 1ns/1ps

module io_ready_combiner import iopred_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       cancel,

    mem_pred_if.sink   mem_a,
    mem_pred_if.sink   mem_b,

    output port_mask_t io_rden_a,
    output port_mask_t io_rden_b,
    output logic       io_ready
);

    logic io_ready_now;
    logic rden_allowed;

    // ---------------------------------------------------------
    // All-ready condition
    // ---------------------------------------------------------

    // Each masked flag is already 1 when its access is not I/O
    assign io_ready_now = mem_a.read_ef_masked & mem_a.write_ef_masked &
                          mem_b.read_ef_masked & mem_b.write_ef_masked;

    // A port read has side effects, so it only goes out when the whole
    // instruction can proceed
    assign rden_allowed = io_ready_now && !cancel;

    assign io_rden_a = rden_allowed ? mem_a.rden_raw : '0;
    assign io_rden_b = rden_allowed ? mem_b.rden_raw : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            io_ready <= 1'b0;
        end else begin
            io_ready <= io_ready_now;
        end
    end

    // ---------------------------------------------------------
    // Checks
    // ---------------------------------------------------------

    a_rden_onehot: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(io_rden_a) && $onehot0(io_rden_b)
    );

    a_rden_cancel: assert property (
        @(posedge clock) disable iff (reset)
        cancel |-> ((io_rden_a == '0) && (io_rden_b == '0))
    );

endmodule

// ==== hdl/memory_io_predication.sv ====
// Per-memory I/O predication

`timescale 1ns/1ps

`include "iopred_consts.svh"

module memory_io_predication import iopred_pkg::*; #(
    parameter int unsigned mem_base  = `MEM_A_BASE,
    parameter int unsigned mem_bound = `MEM_A_BOUND
) (
    input  logic        clock,
    input  logic        reset,

    input  read_addr_t  read_addr,
    input  write_addr_t write_addr,

    input  port_mask_t  read_ef,
    input  port_mask_t  write_ef,

    mem_pred_if.source  results
);

    // Memory range expressed in each address width
    localparam read_addr_t  read_base   = read_addr_t'(mem_base);
    localparam read_addr_t  read_bound  = read_addr_t'(mem_bound);
    localparam write_addr_t write_base  = write_addr_t'(mem_base);
    localparam write_addr_t write_bound = write_addr_t'(mem_bound);

    // First and last local address of the port region
    localparam logic [`MEM_ADDR_WIDTH-1:0] port_first =
        `MEM_ADDR_WIDTH'(`PORT_BASE_ADDR);
    localparam logic [`MEM_ADDR_WIDTH-1:0] port_last =
        `MEM_ADDR_WIDTH'(`PORT_BASE_ADDR + `PORT_COUNT - 1);

    logic                       read_hit;
    logic                       write_hit;
    logic [`MEM_ADDR_WIDTH-1:0] read_local;
    logic [`MEM_ADDR_WIDTH-1:0] write_local;
    logic                       read_io;
    logic                       write_io;
    port_index_t                read_index;
    port_index_t                write_index;

    logic                       read_io_q;
    logic                       write_io_q;
    port_index_t                read_index_q;
    port_index_t                write_index_q;

    // ---------------------------------------------------------
    // Decode, cycle N
    // ---------------------------------------------------------

    assign read_hit  = (read_addr >= read_base) && (read_addr <= read_bound);
    assign write_hit = (write_addr >= write_base) && (write_addr <= write_bound);

    // Only meaningful on a hit, where the offset fits the memory
    assign read_local  = `MEM_ADDR_WIDTH'(read_addr - read_base);
    assign write_local = `MEM_ADDR_WIDTH'(write_addr - write_base);

    assign read_io  = read_hit && (read_local >= port_first) && (read_local <= port_last);
    assign write_io = write_hit && (write_local >= port_first) && (write_local <= port_last);

    assign read_index  = port_index_t'(read_local - port_first);
    assign write_index = port_index_t'(write_local - port_first);

    always_ff @(posedge clock) begin
        if (reset) begin
            read_io_q  <= 1'b0;
            write_io_q <= 1'b0;
        end else begin
            read_io_q  <= read_io;
            write_io_q <= write_io;
        end
    end

    // Indices are only looked at when the matching is-I/O bit is set
    always_ff @(posedge clock) begin
        read_index_q  <= read_index;
        write_index_q <= write_index;
    end

    // ---------------------------------------------------------
    // Flag selection, cycle N+1
    // ---------------------------------------------------------

    assign results.read_is_io  = read_io_q;
    assign results.write_is_io = write_io_q;

    assign results.rden_raw = read_io_q ? (port_mask_t'(1) << read_index_q) : '0;

    // A plain memory access never waits on a port
    assign results.read_ef_masked  = read_io_q ? read_ef[read_index_q] : 1'b1;
    assign results.write_ef_masked = write_io_q ? write_ef[write_index_q] : 1'b1;

    // ---------------------------------------------------------
    // Checks
    // ---------------------------------------------------------

    // A read that missed the port region raises no enable one cycle later
    a_no_rden_off_port: assert property (
        @(posedge clock) disable iff (reset)
        !read_io |=> (!results.read_is_io && (results.rden_raw == '0))
    );

endmodule

// ==== hdl/mem_pred_if.sv ====
// Memory predication result bundle

`timescale 1ns/1ps

interface mem_pred_if import iopred_pkg::*; ();

    // ---------------------------------------------------------
    // Results of one memory, all valid in the cycle after decode
    // ---------------------------------------------------------

    // One-hot read enable for the addressed port, before gating
    port_mask_t rden_raw;

    // Ready flag of the addressed port, or 1 when the access is not I/O
    logic read_ef_masked;
    logic write_ef_masked;

    // The registered address hit the port region of this memory
    logic read_is_io;
    logic write_is_io;

    // Driven by the per-memory predication unit
    modport source (
        output rden_raw,
        output read_ef_masked,
        output write_ef_masked,
        output read_is_io,
        output write_is_io
    );

    // Read by the combiner and by the top level
    modport sink (
        input rden_raw,
        input read_ef_masked,
        input write_ef_masked,
        input read_is_io,
        input write_is_io
    );

endinterface

// ==== hdl/iopred_pkg.sv ====
// I/O predication types

`include "iopred_consts.svh"

package iopred_pkg;

    // ---------------------------------------------------------
    // Address types
    // ---------------------------------------------------------

    // Global read address, covers both data memories
    typedef logic [`READ_ADDR_WIDTH-1:0] read_addr_t;

    // Global write address, one bit wider so it can reach past memory B
    typedef logic [`WRITE_ADDR_WIDTH-1:0] write_addr_t;

    // ---------------------------------------------------------
    // Port types
    // ---------------------------------------------------------

    // One bit per I/O port of a memory
    // Used for ready flags and for read enables
    typedef logic [`PORT_COUNT-1:0] port_mask_t;

    // Number of an I/O port within one memory
    typedef logic [`PORT_ADDR_WIDTH-1:0] port_index_t;

endpackage

// ==== hdl/iopred_consts.svh ====
// I/O predication constants

`ifndef IOPRED_CONSTS_SVH
`define IOPRED_CONSTS_SVH

// ---------------------------------------------------------
// Global address widths
// ---------------------------------------------------------

`define READ_ADDR_WIDTH     11
`define WRITE_ADDR_WIDTH    12

// Address width inside one data memory
`define MEM_ADDR_WIDTH      10

// ---------------------------------------------------------
// Memory ranges as inclusive global addresses
// ---------------------------------------------------------

// Reads and writes share the same range in each memory
`define MEM_A_BASE          0
`define MEM_A_BOUND         1023
`define MEM_B_BASE          1024
`define MEM_B_BOUND         2047

// ---------------------------------------------------------
// I/O port region at the top of each memory
// ---------------------------------------------------------

`define PORT_COUNT          4
`define PORT_BASE_ADDR      1020
`define PORT_ADDR_WIDTH     2

`endif
